//--- record_serializer.sv
`timescale 1ns/1ps

module record_serializer
	import timetag_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       rec_empty,
	input  record_t    rec_in,
	output logic       rec_pop,
	output logic       data_rdy,
	output logic [7:0] data,
	input  logic       data_ack
);

	typedef enum logic [1:0] {
		ST_FETCH,
		ST_LOAD,
		ST_SEND
	} state_t;

	state_t      state;
	logic [2:0]  byte_idx;
	logic [47:0] hold;

	assign rec_pop  = (state == ST_FETCH) && !rec_empty;
	assign data_rdy = (state == ST_SEND);
	assign data     = hold[47:40];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= ST_FETCH;
			byte_idx <= 3'd0;
		end
		else
		begin
			case (state)
				ST_FETCH:
					if (!rec_empty)
						state <= ST_LOAD;
				ST_LOAD:
				begin
					byte_idx <= 3'd0;
					state    <= ST_SEND;
				end
				ST_SEND:
					if (data_ack)
					begin
						byte_idx <= byte_idx + 3'd1;
						// Sixth byte taken
						if (byte_idx == 3'd5)
							state <= ST_FETCH;
					end
				default:
					state <= ST_FETCH;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rec_pop)
			hold <= rec_in;
		else if (data_rdy && data_ack)
			hold <= {hold[39:0], 8'h00};
	end

endmodule

//--- reg_bank.sv
`timescale 1ns/1ps
`include "timetag_consts.svh"

module reg_bank
	import timetag_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  reg_req_t    reg_req,
	output logic [31:0] rd_data,
	output logic [3:0]  strobe_mask,
	input  logic        rec_accepted,
	input  logic        rec_dropped
);

	// Index 0 counts accepted records, index 1 dropped ones
	localparam logic [15:0] CNT_ADDR [2] = '{`TT_REG_REC_COUNT, `TT_REG_REC_LOST};

	logic [31:0] cnt [2];
	logic [1:0]  cnt_inc;

	assign cnt_inc = {rec_dropped, rec_accepted};

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			strobe_mask <= 4'hF;
		else if (reg_req.wr && reg_req.addr == `TT_REG_STROBE_MASK)
			strobe_mask <= reg_req.wdata[3:0];
	end

	// Saturating, any write clears
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < 2; i++)
				cnt[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < 2; i++)
			begin
				if (reg_req.wr && reg_req.addr == CNT_ADDR[i])
					cnt[i] <= '0;
				else if (cnt_inc[i] && cnt[i] != '1)
					cnt[i] <= cnt[i] + 32'd1;
			end
		end
	end

	always_comb
	begin
		rd_data = '0;
		if (reg_req.rd)
		begin
			case (reg_req.addr)
				`TT_REG_VERSION:     rd_data = `TT_HWVERSION;
				`TT_REG_CLOCKRATE:   rd_data = `TT_CLOCKRATE;
				`TT_REG_STROBE_MASK: rd_data = {28'd0, strobe_mask};
				`TT_REG_REC_COUNT:   rd_data = cnt[0];
				`TT_REG_REC_LOST:    rd_data = cnt[1];
				default:             rd_data = '0;
			endcase
		end
	end

endmodule

//--- reg_manager.sv
`timescale 1ns/1ps

module reg_manager
	import timetag_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        cmd_wr,
	input  logic [7:0]  cmd_in,
	output reg_req_t    reg_req,
	input  logic [31:0] rd_data,
	output logic        reply_push,
	output reply_t      reply_item,
	input  logic        reply_room
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ADDR_HI,
		ST_ADDR_LO,
		ST_DATA,
		ST_ISSUE,
		ST_REPLY
	} state_t;

	state_t      state;
	logic        is_write;
	logic [1:0]  byte_cnt;
	logic [15:0] addr_sr;
	logic [31:0] data_sr;
	logic        issue_go;

	// A read holds off until the reply FIFO can take all four bytes
	assign issue_go = (state == ST_ISSUE) && (is_write || reply_room);

	always_comb
	begin
		reg_req.wr    = issue_go && is_write;
		reg_req.rd    = issue_go && !is_write;
		reg_req.addr  = addr_sr;
		reg_req.wdata = data_sr;
	end

	assign reply_push      = (state == ST_REPLY);
	assign reply_item.data = data_sr[31:24];
	assign reply_item.last = (byte_cnt == 2'd3);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= ST_IDLE;
			is_write <= 1'b0;
			byte_cnt <= 2'd0;
		end
		else
		begin
			case (state)
				ST_IDLE:
					if (cmd_wr)
					begin
						case (cmd_op_e'(cmd_in))
							CMD_READ:
							begin
								is_write <= 1'b0;
								state    <= ST_ADDR_HI;
							end
							CMD_WRITE:
							begin
								is_write <= 1'b1;
								state    <= ST_ADDR_HI;
							end
							default:
								state <= ST_IDLE;
						endcase
					end
				ST_ADDR_HI:
					if (cmd_wr)
						state <= ST_ADDR_LO;
				ST_ADDR_LO:
					if (cmd_wr)
					begin
						byte_cnt <= 2'd0;
						state    <= is_write ? ST_DATA : ST_ISSUE;
					end
				ST_DATA:
					if (cmd_wr)
					begin
						byte_cnt <= byte_cnt + 2'd1;
						if (byte_cnt == 2'd3)
							state <= ST_ISSUE;
					end
				ST_ISSUE:
					if (issue_go)
					begin
						byte_cnt <= 2'd0;
						state    <= is_write ? ST_IDLE : ST_REPLY;
					end
				ST_REPLY:
				begin
					byte_cnt <= byte_cnt + 2'd1;
					if (byte_cnt == 2'd3)
						state <= ST_IDLE;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Address and data shifters, MSB first; data_sr also carries the read reply
	always_ff @(posedge clk)
	begin
		if (cmd_wr && (state == ST_ADDR_HI || state == ST_ADDR_LO))
			addr_sr <= {addr_sr[7:0], cmd_in};
		if (cmd_wr && state == ST_DATA)
			data_sr <= {data_sr[23:0], cmd_in};
		else if (issue_go && !is_write)
			data_sr <= rd_data;
		else if (state == ST_REPLY)
			data_sr <= {data_sr[23:0], 8'h00};
	end

endmodule

//--- sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 8
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   push,
	input  payload_t               din,
	output logic                   full,
	input  logic                   pop,
	output payload_t               dout,
	output logic                   empty,
	output logic [$clog2(DEPTH):0] count
);

	localparam int AW = $clog2(DEPTH);

	payload_t      mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic          do_push;
	logic          do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;
	assign full    = (count == DEPTH);
	assign empty   = (count == '0);
	// Show-ahead, head always on dout
	assign dout    = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- tag_timer.sv
`timescale 1ns/1ps

module tag_timer
	import timetag_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic [3:0] strobe_in,
	input  logic [3:0] delta_in,
	input  logic [3:0] strobe_mask,
	output logic       rec_valid,
	output record_t    rec
);

	logic [38:0] timestamp;
	logic [3:0]  strobe_q;
	logic [3:0]  strobe_prev;
	logic [3:0]  delta_q;
	logic [3:0]  rise;
	logic        det_valid;
	logic [3:0]  det_strobes;
	logic [3:0]  det_delta;
	logic [38:0] det_stamp;

	assign rise = strobe_q & ~strobe_prev & strobe_mask;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			timestamp   <= '0;
			strobe_q    <= 4'd0;
			strobe_prev <= 4'd0;
			det_valid   <= 1'b0;
			rec_valid   <= 1'b0;
		end
		else
		begin
			// Free running, wraps
			timestamp   <= timestamp + 39'd1;
			strobe_q    <= strobe_in;
			strobe_prev <= strobe_q;
			det_valid   <= |rise;
			rec_valid   <= det_valid;
		end
	end

	// Delta sampled together with the strobes
	always_ff @(posedge clk)
	begin
		delta_q     <= delta_in;
		det_strobes <= rise;
		det_delta   <= delta_q;
		det_stamp   <= timestamp;
	end

	always_ff @(posedge clk)
	begin
		rec.lost      <= 1'b0;
		rec.strobes   <= det_strobes;
		rec.delta     <= det_delta;
		rec.timestamp <= det_stamp;
	end

endmodule

//--- tb_timetag.sv
`timescale 1ns/1ps
`include "timetag_consts.svh"

module tb_timetag
	import timetag_pkg::*;
();

	localparam int TIMEOUT = 200;

	logic       clk;
	logic       arst_n;
	logic       cmd_wr;
	logic [7:0] cmd_in;
	logic       reply_rdy;
	logic [7:0] reply;
	logic       reply_ack;
	logic       reply_end;
	logic       data_rdy;
	logic [7:0] data;
	logic       data_ack;
	logic [3:0] strobe_in;
	logic [3:0] delta_in;

	logic [31:0] rng;
	// Expected records as {strobes, delta}
	logic [7:0]  exp_q [$];
	logic [38:0] last_stamp;

	timetag dut (.*);

	always #20 clk = ~clk;

	always @(negedge clk)
	begin
		if (dut.checks.fail_count != 0)
			abort_run("A bound assertion on the DUT failed");
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp)
		else
			abort_run($sformatf("Mismatch at %0t: %s got %0h expected %0h",
				$time, what, got, exp));
	endtask

	task automatic send_byte(input logic [7:0] b);
		@(posedge clk);
		cmd_wr <= 1'b1;
		cmd_in <= b;
		@(posedge clk);
		cmd_wr <= 1'b0;
	endtask

	task automatic write_reg(input logic [15:0] addr, input logic [31:0] value);
		send_byte(CMD_WRITE);
		send_byte(addr[15:8]);
		send_byte(addr[7:0]);
		for (int i = 3; i >= 0; i--)
			send_byte(value[i*8 +: 8]);
	endtask

	task automatic wait_reply();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!reply_rdy)
		begin
			waited++;
			if (waited > TIMEOUT)
				abort_run("Timeout waiting for reply_rdy");
			@(negedge clk);
		end
	endtask

	task automatic wait_data();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!data_rdy)
		begin
			waited++;
			if (waited > TIMEOUT)
				abort_run("Timeout waiting for data_rdy");
			@(negedge clk);
		end
	endtask

	task automatic read_reg(input logic [15:0] addr, output logic [31:0] value);
		value = '0;
		send_byte(CMD_READ);
		send_byte(addr[15:8]);
		send_byte(addr[7:0]);
		for (int i = 0; i < 4; i++)
		begin
			wait_reply();
			check_value("reply_end", reply_end, i == 3);
			value = {value[23:0], reply};
			@(posedge clk);
			reply_ack <= 1'b1;
			@(posedge clk);
			reply_ack <= 1'b0;
		end
	endtask

	task automatic expect_reg(input logic [15:0] addr, input logic [31:0] exp);
		logic [31:0] got;
		read_reg(addr, got);
		check_value($sformatf("register %0h", addr), got, exp);
	endtask

	task automatic pulse_strobes(input logic [3:0] pattern, input logic [3:0] d);
		@(posedge clk);
		strobe_in <= pattern;
		delta_in  <= d;
		@(posedge clk);
		strobe_in <= 4'd0;
		repeat (2) @(posedge clk);
	endtask

	// All channels enabled here
	task automatic random_event();
		logic [3:0] pattern;
		rng = xorshift32(rng);
		pattern = rng[3:0];
		if (pattern == 4'd0)
			pattern = 4'b1000;
		exp_q.push_back({pattern, rng[7:4]});
		pulse_strobes(pattern, rng[7:4]);
		repeat (rng[9:8]) @(posedge clk);
	endtask

	task automatic read_record(output record_t r);
		logic [47:0] bits;
		bits = '0;
		for (int i = 0; i < 6; i++)
		begin
			wait_data();
			bits = {bits[39:0], data};
			rng = xorshift32(rng);
			repeat (rng[1:0]) @(posedge clk);
			@(posedge clk);
			data_ack <= 1'b1;
			@(posedge clk);
			data_ack <= 1'b0;
		end
		r = record_t'(bits);
	endtask

	task automatic check_next_record(input logic exp_lost);
		record_t    r;
		logic [7:0] exp;
		read_record(r);
		if (exp_q.size() == 0)
			abort_run("A record arrived when none was expected");
		exp = exp_q.pop_front();
		check_value("record strobes", r.strobes, exp[7:4]);
		check_value("record delta", r.delta, exp[3:0]);
		check_value("record lost", r.lost, exp_lost);
		assert (r.timestamp > last_stamp)
		else
			abort_run($sformatf("Mismatch at %0t: timestamp %0d not above %0d",
				$time, r.timestamp, last_stamp));
		last_stamp = r.timestamp;
	endtask

	task automatic clear_counters();
		write_reg(`TT_REG_REC_COUNT, 32'd0);
		write_reg(`TT_REG_REC_LOST, 32'hdead_beef);
		expect_reg(`TT_REG_REC_COUNT, 32'd0);
		expect_reg(`TT_REG_REC_LOST, 32'd0);
	endtask

	initial
	begin
		int extra;
		clk        = 1'b0;
		arst_n     = 1'b1;
		cmd_wr     = 1'b0;
		cmd_in     = 8'd0;
		reply_ack  = 1'b0;
		data_ack   = 1'b0;
		strobe_in  = 4'd0;
		delta_in   = 4'd0;
		rng        = 32'h3b3b_a7dd;
		last_stamp = '0;
		@(posedge clk);
		arst_n <= 1'b0;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;

		// Constants, reset values, unknown address
		expect_reg(`TT_REG_VERSION, `TT_HWVERSION);
		expect_reg(`TT_REG_CLOCKRATE, `TT_CLOCKRATE);
		expect_reg(`TT_REG_STROBE_MASK, 32'h0000_000F);
		expect_reg(`TT_REG_REC_COUNT, 32'd0);
		expect_reg(`TT_REG_REC_LOST, 32'd0);
		expect_reg(16'h0004, 32'd0);

		// Masked channels 1 and 3
		write_reg(`TT_REG_STROBE_MASK, 32'h0000_0005);
		expect_reg(`TT_REG_STROBE_MASK, 32'h0000_0005);
		pulse_strobes(4'b1010, 4'h3);
		pulse_strobes(4'b1010, 4'hC);
		expect_reg(`TT_REG_REC_COUNT, 32'd0);
		@(negedge clk);
		check_value("data_rdy with masked strobes", data_rdy, 1'b0);
		exp_q.push_back({4'b0001, 4'h9});
		pulse_strobes(4'b0011, 4'h9);
		check_next_record(1'b0);
		write_reg(`TT_REG_STROBE_MASK, 32'h0000_000F);

		repeat (5)
			random_event();
		repeat (5)
			check_next_record(1'b0);

		// Overflow with data_ack held low; one record waits in the serializer
		clear_counters();
		repeat (12)
			random_event();
		extra = 12 - (`TT_REC_FIFO_DEPTH + 1);
		repeat (extra)
			void'(exp_q.pop_back());
		expect_reg(`TT_REG_REC_COUNT, `TT_REC_FIFO_DEPTH + 1);
		expect_reg(`TT_REG_REC_LOST, extra);
		repeat (`TT_REC_FIFO_DEPTH + 1)
			check_next_record(1'b0);
		random_event();
		check_next_record(1'b1);
		random_event();
		check_next_record(1'b0);

		clear_counters();

		if (dut.checks.fail_count == 0)
		begin
			$display("Verification passed");
			$finish;
		end
		else
			abort_run("Bound assertions on the DUT reported failures");
	end

endmodule

//--- timetag.f
+incdir+.
timetag_pkg.sv
sync_fifo.sv
reg_manager.sv
reg_bank.sv
tag_timer.sv
record_serializer.sv
timetag.sv
timetag_assert.sv
tb_timetag.sv

//--- timetag.sv
`timescale 1ns/1ps
`include "timetag_consts.svh"

module timetag
	import timetag_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       cmd_wr,
	input  logic [7:0] cmd_in,
	output logic       reply_rdy,
	output logic [7:0] reply,
	input  logic       reply_ack,
	output logic       reply_end,
	output logic       data_rdy,
	output logic [7:0] data,
	input  logic       data_ack,
	input  logic [3:0] strobe_in,
	input  logic [3:0] delta_in
);

	reg_req_t    reg_req;
	logic [31:0] rd_data;
	logic [3:0]  strobe_mask;

	logic        reply_push;
	reply_t      reply_item;
	reply_t      reply_head;
	logic        reply_empty;
	logic        reply_room;
	logic [$clog2(`TT_REPLY_FIFO_DEPTH):0] reply_count;

	logic        rec_valid;
	record_t     rec_raw;
	record_t     rec_tagged;
	record_t     rec_head;
	logic        rec_full;
	logic        rec_empty;
	logic        rec_pop;
	logic        rec_accept;
	logic        rec_drop;
	logic        lost_flag;

	reg_manager u_reg_manager (
		.clk        (clk),
		.arst_n     (arst_n),
		.cmd_wr     (cmd_wr),
		.cmd_in     (cmd_in),
		.reg_req    (reg_req),
		.rd_data    (rd_data),
		.reply_push (reply_push),
		.reply_item (reply_item),
		.reply_room (reply_room)
	);

	reg_bank u_reg_bank (
		.clk          (clk),
		.arst_n       (arst_n),
		.reg_req      (reg_req),
		.rd_data      (rd_data),
		.strobe_mask  (strobe_mask),
		.rec_accepted (rec_accept),
		.rec_dropped  (rec_drop)
	);

	// Room for a whole four-byte reply
	assign reply_room = (reply_count <= `TT_REPLY_FIFO_DEPTH - 4);

	sync_fifo #(
		.payload_t (reply_t),
		.DEPTH     (`TT_REPLY_FIFO_DEPTH)
	) u_reply_fifo (
		.clk    (clk),
		.arst_n (arst_n),
		.push   (reply_push),
		.din    (reply_item),
		.full   (),
		.pop    (reply_ack),
		.dout   (reply_head),
		.empty  (reply_empty),
		.count  (reply_count)
	);

	assign reply_rdy = !reply_empty;
	assign reply     = reply_head.data;
	assign reply_end = !reply_empty && reply_head.last;

	tag_timer u_tag_timer (
		.clk         (clk),
		.arst_n      (arst_n),
		.strobe_in   (strobe_in),
		.delta_in    (delta_in),
		.strobe_mask (strobe_mask),
		.rec_valid   (rec_valid),
		.rec         (rec_raw)
	);

	assign rec_accept = rec_valid && !rec_full;
	assign rec_drop   = rec_valid && rec_full;

	always_comb
	begin
		rec_tagged      = rec_raw;
		rec_tagged.lost = lost_flag;
	end

	// Set by a drop, cleared once a record gets through carrying it
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			lost_flag <= 1'b0;
		else if (rec_drop)
			lost_flag <= 1'b1;
		else if (rec_accept)
			lost_flag <= 1'b0;
	end

	sync_fifo #(
		.payload_t (record_t),
		.DEPTH     (`TT_REC_FIFO_DEPTH)
	) u_rec_fifo (
		.clk    (clk),
		.arst_n (arst_n),
		.push   (rec_accept),
		.din    (rec_tagged),
		.full   (rec_full),
		.pop    (rec_pop),
		.dout   (rec_head),
		.empty  (rec_empty),
		.count  ()
	);

	record_serializer u_record_serializer (
		.clk       (clk),
		.arst_n    (arst_n),
		.rec_empty (rec_empty),
		.rec_in    (rec_head),
		.rec_pop   (rec_pop),
		.data_rdy  (data_rdy),
		.data      (data),
		.data_ack  (data_ack)
	);

endmodule

//--- timetag_assert.sv
`timescale 1ns/1ps

module timetag_assert
	import timetag_pkg::*;
(
	input logic    clk,
	input logic    arst_n,
	input logic    reply_rdy,
	input logic    reply_end,
	input logic    reply_ack,
	input logic    data_rdy,
	input logic [7:0] data,
	input logic    data_ack,
	input logic    rec_accept,
	input record_t rec_tagged
);

	int fail_count = 0;

	a_end_has_rdy: assert property (@(posedge clk) disable iff (!arst_n)
		reply_end |-> reply_rdy)
	else
	begin
		$error("reply_end high while reply_rdy is low");
		fail_count++;
	end

	a_reply_ack_rdy: assert property (@(posedge clk) disable iff (!arst_n)
		reply_ack |-> reply_rdy)
	else
	begin
		$error("reply_ack pulsed with no reply byte waiting");
		fail_count++;
	end

	// Byte holds until the host takes it
	a_data_stable: assert property (@(posedge clk) disable iff (!arst_n)
		data_rdy && !data_ack |=> data_rdy && $stable(data))
	else
	begin
		$error("data changed while data_rdy was high and no ack came");
		fail_count++;
	end

	a_data_ack_rdy: assert property (@(posedge clk) disable iff (!arst_n)
		data_ack |-> data_rdy)
	else
	begin
		$error("data_ack pulsed with no data byte waiting");
		fail_count++;
	end

	a_reset_quiet: assert property (@(posedge clk)
		!arst_n |-> !reply_rdy && !data_rdy && !reply_end)
	else
	begin
		$error("host outputs active during reset");
		fail_count++;
	end

	a_rec_has_strobe: assert property (@(posedge clk) disable iff (!arst_n)
		rec_accept |-> rec_tagged.strobes != 4'd0)
	else
	begin
		$error("accepted record carries no strobe");
		fail_count++;
	end

endmodule

bind timetag timetag_assert checks (.*);

//--- timetag_consts.svh
`ifndef TIMETAG_CONSTS_SVH
`define TIMETAG_CONSTS_SVH

`define TT_HWVERSION        32'h0001_0003
// 25 MHz system clock
`define TT_CLOCKRATE        32'd25_000_000

`define TT_REG_VERSION      16'h0001
`define TT_REG_CLOCKRATE    16'h0002
`define TT_REG_STROBE_MASK  16'h0003
`define TT_REG_REC_COUNT    16'h0006
`define TT_REG_REC_LOST     16'h0007

`define TT_REC_FIFO_DEPTH   8
`define TT_REPLY_FIFO_DEPTH 8

`endif

//--- timetag_pkg.sv
package timetag_pkg;

	// One tagged event, 48 bits, lost flag on top
	typedef struct packed {
		logic        lost;
		logic [3:0]  strobes;
		logic [3:0]  delta;
		logic [38:0] timestamp;
	} record_t;

	// Reply byte to the host with its end mark
	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} reply_t;

	// Single-cycle register access
	typedef struct packed {
		logic        wr;
		logic        rd;
		logic [15:0] addr;
		logic [31:0] wdata;
	} reg_req_t;

	// First byte of every host command
	typedef enum logic [7:0] {
		CMD_READ  = 8'h01,
		CMD_WRITE = 8'h02
	} cmd_op_e;

endpackage
